//--- opll_reg.f
+incdir+hdl
hdl/opll_reg_pkg.sv
hdl/opll_patch_if.sv
hdl/opll_bus_sync.sv
hdl/opll_custom_patch.sv
hdl/opll_chan_regs.sv
hdl/opll_inst_rom.sv
hdl/opll_param_select.sv
hdl/opll_reg_top.sv
verif/tb_clkgen.sv
verif/opll_reg_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0 -Wno-fatal
TOP      = opll_reg_tb
FILELIST = opll_reg.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/opll_reg_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "opll_reg_config.svh"

module opll_reg_tb import opll_reg_pkg::*; ();

// eight register bytes of one patch, byte 0 first
typedef logic [0:7][7:0] patch_regs_t;

// expected fields of one operator
typedef struct packed {
    tl_t    tl;
    logic   dc;
    logic   dm;
    fb_t    fb;
    logic   am;
    logic   pm;
    logic   etyp;
    logic   ksr;
    mul_t   mul;
    ksl_t   ksl;
    rate_t  ar;
    rate_t  dr;
    rate_t  sl;
    rate_t  rr;
} op_exp_t;

// built-in violin and organ patches in register byte form
localparam patch_regs_t row1_ref = {8'h71, 8'h61, 8'h1E, 8'h17, 8'hD0, 8'h78, 8'h00, 8'h17};
localparam patch_regs_t row8_ref = {8'h23, 8'h21, 8'h2D, 8'h14, 8'hA2, 8'h72, 8'h00, 8'h07};

logic   clk, rst_n;
logic   cpu_cs_n, cpu_wr_n, cpu_a0;
byte_t  cpu_d;

ch_t    o_CH;
logic   o_CAR, o_KON, o_SUSEN, o_DC, o_DM, o_AM, o_PM, o_ETYP, o_KSR;
fnum_t  o_FNUM;
block_t o_BLOCK;
tl_t    o_TL;
fb_t    o_FB;
mul_t   o_MUL;
ksl_t   o_KSL;
rate_t  o_AR, o_DR, o_SL, o_RR;

int     errors;

// register model
patch_regs_t    cust_regs;
fnum_t          m_fnum  [`OPLL_NUM_CH];
block_t         m_block [`OPLL_NUM_CH];
logic           m_kon   [`OPLL_NUM_CH];
logic           m_sus   [`OPLL_NUM_CH];
inst_t          m_inst  [`OPLL_NUM_CH];
vol_t           m_vol   [`OPLL_NUM_CH];

tb_clkgen u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
);

opll_reg_top i_opll_reg_top (
    .i_EMUCLK (clk),
    .i_RST_n  (rst_n),
    .i_CS_n   (cpu_cs_n),
    .i_WR_n   (cpu_wr_n),
    .i_A0     (cpu_a0),
    .i_D      (cpu_d),
    .o_CH     (o_CH),
    .o_CAR    (o_CAR),
    .o_FNUM   (o_FNUM),
    .o_BLOCK  (o_BLOCK),
    .o_KON    (o_KON),
    .o_SUSEN  (o_SUSEN),
    .o_TL     (o_TL),
    .o_DC     (o_DC),
    .o_DM     (o_DM),
    .o_FB     (o_FB),
    .o_AM     (o_AM),
    .o_PM     (o_PM),
    .o_ETYP   (o_ETYP),
    .o_KSR    (o_KSR),
    .o_MUL    (o_MUL),
    .o_KSL    (o_KSL),
    .o_AR     (o_AR),
    .o_DR     (o_DR),
    .o_SL     (o_SL),
    .o_RR     (o_RR)
);

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

function automatic patch_regs_t ref_regs(input inst_t inst);
    case (inst)
        4'd1:    return row1_ref;
        4'd8:    return row8_ref;
        default: return cust_regs;  // instrument 0, user patch
    endcase
endfunction

// split register bytes as laid out in the chip
function automatic op_exp_t decode_op(input patch_regs_t r, input bit car,
                                      input logic kon, input vol_t vol);
    op_exp_t e;
    byte_t   flags;
    byte_t   rates;
    byte_t   levels;
    flags  = car ? r[1] : r[0];
    rates  = car ? r[5] : r[4];
    levels = car ? r[7] : r[6];
    e.am   = flags[7];
    e.pm   = flags[6];
    e.etyp = flags[5];
    e.ksr  = flags[4];
    e.mul  = flags[3:0];
    e.ksl  = car ? r[3][7:6] : r[2][7:6];
    e.tl   = r[2][5:0];
    e.dc   = r[3][4];
    e.dm   = r[3][3];
    e.fb   = r[3][2:0];
    e.ar   = rates[7:4];
    e.dr   = rates[3:0];
    e.sl   = levels[7:4];
    e.rr   = levels[3:0];
    if (car) begin
        e.tl = {vol, 2'b00};    // carrier level from channel volume
    end
    if (!car && !kon) begin
        e.ar = '0;
        e.dr = '0;
        e.rr = '0;
    end
    return e;
endfunction

//////////////////////////////////////////////////////////////////////
// bus model and helpers
//////////////////////////////////////////////////////////////////////

task automatic cpu_write(input logic a0, input byte_t data);
    @(posedge clk);
    #1;
    cpu_cs_n = 1'b0;
    cpu_wr_n = 1'b0;
    cpu_a0   = a0;
    cpu_d    = data;
    repeat (4) @(posedge clk);
    #1;
    cpu_cs_n = 1'b1;    // data kept on the bus
    cpu_wr_n = 1'b1;
    repeat (4) @(posedge clk);
endtask

task automatic write_reg(input byte_t addr, input byte_t data);
    int idx;
    idx = addr[3:0];
    cpu_write(1'b0, addr);
    cpu_write(1'b1, data);
    if (addr <= `OPLL_CUSTOM_LAST) begin
        cust_regs[addr[2:0]] = data;
    end else if (idx < `OPLL_NUM_CH) begin
        case (addr[7:4])
            4'h1: m_fnum[idx][7:0] = data;
            4'h2: begin
                m_fnum[idx][8] = data[0];
                m_block[idx]   = data[3:1];
                m_kon[idx]     = data[4];
                m_sus[idx]     = data[5];
            end
            4'h3: begin
                m_inst[idx] = data[7:4];
                m_vol[idx]  = data[3:0];
            end
            default: ;
        endcase
    end
    repeat (40) @(posedge clk);
endtask

task automatic wait_slot(input int ch, input bit car);
    int n;
    n = 0;
    @(posedge clk);
    #1;
    while ((o_CH !== 4'(ch) || o_CAR !== car) && n < 60) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (n >= 60) begin
        errors++;
        $display("Timeout: slot of channel %0d phase %0d never showed up", ch, car);
    end
endtask

task automatic compare(input string test, input string field,
                       input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
        errors++;
        $display("Mismatch %s %s ch %0d car %0d: expected %0h, actual %0h",
                 test, field, o_CH, o_CAR, exp, act);
    end
endtask

task automatic check_slot(input string test, input int ch, input bit car);
    op_exp_t e;
    wait_slot(ch, car);
    e = decode_op(ref_regs(m_inst[ch]), car, m_kon[ch], m_vol[ch]);
    compare(test, "FNUM",  m_fnum[ch],  o_FNUM);
    compare(test, "BLOCK", m_block[ch], o_BLOCK);
    compare(test, "KON",   m_kon[ch],   o_KON);
    compare(test, "SUSEN", m_sus[ch],   o_SUSEN);
    compare(test, "TL",    e.tl,   o_TL);
    compare(test, "DC",    e.dc,   o_DC);
    compare(test, "DM",    e.dm,   o_DM);
    compare(test, "FB",    e.fb,   o_FB);
    compare(test, "AM",    e.am,   o_AM);
    compare(test, "PM",    e.pm,   o_PM);
    compare(test, "ETYP",  e.etyp, o_ETYP);
    compare(test, "KSR",   e.ksr,  o_KSR);
    compare(test, "MUL",   e.mul,  o_MUL);
    compare(test, "KSL",   e.ksl,  o_KSL);
    compare(test, "AR",    e.ar,   o_AR);
    compare(test, "DR",    e.dr,   o_DR);
    compare(test, "SL",    e.sl,   o_SL);
    compare(test, "RR",    e.rr,   o_RR);
endtask

// walks the slots in counter order
task automatic check_all(input string test);
    for (int ch = 0; ch < `OPLL_NUM_CH; ch++) begin
        check_slot(test, ch, 1'b0);
        check_slot(test, ch, 1'b1);
    end
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset();
    check_all("reset");
endtask

task automatic test_chan_fields();
    int    ch;
    fnum_t fnum;
    byte_t hi;
    repeat (4) begin
        ch    = $urandom % `OPLL_NUM_CH;
        fnum  = fnum_t'($urandom);
        hi    = byte_t'($urandom) & 8'h3f;
        hi[0] = fnum[8];
        write_reg(8'(`OPLL_ADDR_FNUM_LO + ch), fnum[7:0]);
        write_reg(8'(`OPLL_ADDR_FNUM_HI + ch), hi);
        write_reg(8'(`OPLL_ADDR_INST + ch), {4'h0, vol_t'($urandom)});
        check_all("chan_fields");   // other channels must keep their values
    end
endtask

task automatic test_rom_patch();
    int ch;
    ch = $urandom % `OPLL_NUM_CH;
    write_reg(8'(`OPLL_ADDR_INST + ch), {4'd1, vol_t'($urandom)});
    write_reg(8'(`OPLL_ADDR_FNUM_HI + ch),
              {2'b00, m_sus[ch], 1'b1, m_block[ch], m_fnum[ch][8]});
    check_slot("rom_patch", ch, 1'b0);
    check_slot("rom_patch", ch, 1'b1);
    write_reg(8'(`OPLL_ADDR_INST + ch), {4'd8, vol_t'($urandom)});
    check_slot("rom_patch", ch, 1'b0);
    check_slot("rom_patch", ch, 1'b1);
endtask

task automatic test_custom_patch();
    int ch;
    ch = $urandom % `OPLL_NUM_CH;
    write_reg(8'(`OPLL_ADDR_INST + ch), {4'd0, vol_t'($urandom)});
    for (int a = 0; a <= `OPLL_CUSTOM_LAST; a++) begin
        write_reg(8'(a), byte_t'($urandom));
    end
    check_all("custom_patch");
endtask

task automatic test_rate_mask();
    int ch;
    ch = $urandom % `OPLL_NUM_CH;
    write_reg(8'(`OPLL_ADDR_INST + ch), {4'd8, m_vol[ch]});
    write_reg(8'(`OPLL_ADDR_FNUM_HI + ch),
              {2'b00, m_sus[ch], 1'b0, m_block[ch], m_fnum[ch][8]});
    check_slot("rate_mask", ch, 1'b0);  // modulator rates held at zero
    check_slot("rate_mask", ch, 1'b1);
    write_reg(8'(`OPLL_ADDR_FNUM_HI + ch),
              {2'b00, m_sus[ch], 1'b1, m_block[ch], m_fnum[ch][8]});
    check_slot("rate_mask", ch, 1'b0);
    check_slot("rate_mask", ch, 1'b1);
endtask

task automatic test_bad_addr();
    write_reg(8'h0A, byte_t'($urandom));
    write_reg(8'h19, byte_t'($urandom));
    write_reg(8'h3C, byte_t'($urandom));
    // a valid address first, so a high address that is not rejected
    // would land on channel 0
    write_reg(`OPLL_ADDR_FNUM_LO, m_fnum[0][7:0]);
    write_reg(8'h50, ~m_fnum[0][7:0]);
    check_all("bad_addr");
endtask

//////////////////////////////////////////////////////////////////////
// main sequence
//////////////////////////////////////////////////////////////////////

initial begin
    int n;
    errors    = 0;
    cpu_cs_n  = 1'b1;
    cpu_wr_n  = 1'b1;
    cpu_a0    = 1'b0;
    cpu_d     = '0;
    cust_regs = '0;
    void'($urandom(32'h17dd_90ef));
    for (int c = 0; c < `OPLL_NUM_CH; c++) begin
        m_fnum[c]  = '0;
        m_block[c] = '0;
        m_kon[c]   = 1'b0;
        m_sus[c]   = 1'b0;
        m_inst[c]  = '0;
        m_vol[c]   = '0;
    end

    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
        @(posedge clk);
        n++;
    end
    if (rst_n !== 1'b1) begin
        errors++;
        $display("Reset was never released");
    end

    test_reset();
    test_chan_fields();
    test_rom_patch();
    test_custom_patch();
    test_rate_mask();
    test_bad_addr();

    $display("errors: %0d", errors);
    if (errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic    o_clk,
    output logic    o_rst_n
);

initial begin
    o_clk = 1'b0;
    forever begin
        #2 o_clk = ~o_clk;  // 4 ns period
    end
end

initial begin
    o_rst_n = 1'b0;
    repeat (5) @(posedge o_clk);
    #1 o_rst_n = 1'b1;      // release off the edge like other stimulus
end

endmodule

`default_nettype wire

//--- hdl/opll_reg_top.sv
`timescale 1ns/100ps
`default_nettype none

module opll_reg_top import opll_reg_pkg::*; (
    input  logic    i_EMUCLK,
    input  logic    i_RST_n,
    input  logic    i_CS_n,
    input  logic    i_WR_n,
    input  logic    i_A0,
    input  byte_t   i_D,
    output ch_t     o_CH,
    output logic    o_CAR,
    output fnum_t   o_FNUM,
    output block_t  o_BLOCK,
    output logic    o_KON,
    output logic    o_SUSEN,
    output tl_t     o_TL,
    output logic    o_DC,
    output logic    o_DM,
    output fb_t     o_FB,
    output logic    o_AM,
    output logic    o_PM,
    output logic    o_ETYP,
    output logic    o_KSR,
    output mul_t    o_MUL,
    output ksl_t    o_KSL,
    output rate_t   o_AR,
    output rate_t   o_DR,
    output rate_t   o_SL,
    output rate_t   o_RR
);

logic           addr_wr, data_wr;
byte_t          wr_data;
slot_t          slot;
ch_t            ch;
slot_phase_e    car;

fnum_t          fnum;
block_t         block;
logic           kon, susen;
inst_t          inst;
vol_t           vol;

opll_patch_if   patch_rom ();
opll_patch_if   patch_cust ();

// stage 0 addressing for the register blocks
assign ch  = slot[4:1];
assign car = slot[0] ? carrier : modulator;

opll_bus_sync u_bus_sync (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .i_CS_n    (i_CS_n),
    .i_WR_n    (i_WR_n),
    .i_A0      (i_A0),
    .i_D       (i_D),
    .o_addr_wr (addr_wr),
    .o_data_wr (data_wr),
    .o_wr_data (wr_data)
);

opll_custom_patch u_custom_patch (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .i_addr_wr (addr_wr),
    .i_data_wr (data_wr),
    .i_wr_data (wr_data),
    .i_car     (car),
    .o_patch   (patch_cust.source)
);

opll_chan_regs u_chan_regs (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .i_addr_wr (addr_wr),
    .i_data_wr (data_wr),
    .i_wr_data (wr_data),
    .i_ch      (ch),
    .o_fnum    (fnum),
    .o_block   (block),
    .o_kon     (kon),
    .o_susen   (susen),
    .o_inst    (inst),
    .o_vol     (vol)
);

opll_inst_rom u_inst_rom (
    .i_EMUCLK  (i_EMUCLK),
    .i_inst    (inst),
    .i_car     (car),
    .o_patch   (patch_rom.source)
);

opll_param_select u_param_select (
    .i_EMUCLK  (i_EMUCLK),
    .i_RST_n   (i_RST_n),
    .o_slot    (slot),
    .i_inst    (inst),
    .i_vol     (vol),
    .i_fnum    (fnum),
    .i_block   (block),
    .i_kon     (kon),
    .i_susen   (susen),
    .i_rom     (patch_rom.sink),
    .i_cust    (patch_cust.sink),
    .o_CH      (o_CH),
    .o_CAR     (o_CAR),
    .o_FNUM    (o_FNUM),
    .o_BLOCK   (o_BLOCK),
    .o_KON     (o_KON),
    .o_SUSEN   (o_SUSEN),
    .o_TL      (o_TL),
    .o_DC      (o_DC),
    .o_DM      (o_DM),
    .o_FB      (o_FB),
    .o_AM      (o_AM),
    .o_PM      (o_PM),
    .o_ETYP    (o_ETYP),
    .o_KSR     (o_KSR),
    .o_MUL     (o_MUL),
    .o_KSL     (o_KSL),
    .o_AR      (o_AR),
    .o_DR      (o_DR),
    .o_SL      (o_SL),
    .o_RR      (o_RR)
);

endmodule

`default_nettype wire

//--- hdl/opll_param_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "opll_reg_config.svh"

module opll_param_select import opll_reg_pkg::*; (
    input  logic            i_EMUCLK,
    input  logic            i_RST_n,
    output slot_t           o_slot,
    input  inst_t           i_inst,
    input  vol_t            i_vol,
    input  fnum_t           i_fnum,
    input  block_t          i_block,
    input  logic            i_kon,
    input  logic            i_susen,
    opll_patch_if.sink      i_rom,
    opll_patch_if.sink      i_cust,
    output ch_t             o_CH,
    output logic            o_CAR,
    output fnum_t           o_FNUM,
    output block_t          o_BLOCK,
    output logic            o_KON,
    output logic            o_SUSEN,
    output tl_t             o_TL,
    output logic            o_DC,
    output logic            o_DM,
    output fb_t             o_FB,
    output logic            o_AM,
    output logic            o_PM,
    output logic            o_ETYP,
    output logic            o_KSR,
    output mul_t            o_MUL,
    output ksl_t            o_KSL,
    output rate_t           o_AR,
    output rate_t           o_DR,
    output rate_t           o_SL,
    output rate_t           o_RR
);

//////////////////////////////////////////////////////////////////////
// stage 0, slot counter
//////////////////////////////////////////////////////////////////////

slot_t slot_q;

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        slot_q <= '0;
    end else if (slot_q == slot_t'(`OPLL_NUM_SLOT - 1)) begin
        slot_q <= '0;
    end else begin
        slot_q <= slot_q + 1'b1;
    end
end

assign o_slot = slot_q;

//////////////////////////////////////////////////////////////////////
// stage 1, channel fields beside the registered patches
//////////////////////////////////////////////////////////////////////

slot_t          slot1;
inst_t          inst1;
vol_t           vol1;
fnum_t          fnum1;
block_t         block1;
logic           kon1, susen1;
slot_phase_e    ph1;
logic           use_cust;

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        slot1  <= '0;
        inst1  <= '0;
        vol1   <= '0;
        fnum1  <= '0;
        block1 <= '0;
        kon1   <= 1'b0;
        susen1 <= 1'b0;
    end else begin
        slot1  <= slot_q;
        inst1  <= i_inst;
        vol1   <= i_vol;
        fnum1  <= i_fnum;
        block1 <= i_block;
        kon1   <= i_kon;
        susen1 <= i_susen;
    end
end

assign ph1      = slot1[0] ? carrier : modulator;
assign use_cust = (inst1 == '0);    // instrument 0 is the user patch

//////////////////////////////////////////////////////////////////////
// stage 2, output registers
//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        o_CH    <= '0;
        o_CAR   <= 1'b0;
        o_FNUM  <= '0;
        o_BLOCK <= '0;
        o_KON   <= 1'b0;
        o_SUSEN <= 1'b0;
        o_TL    <= '0;
        o_DC    <= 1'b0;
        o_DM    <= 1'b0;
        o_FB    <= '0;
        o_AM    <= 1'b0;
        o_PM    <= 1'b0;
        o_ETYP  <= 1'b0;
        o_KSR   <= 1'b0;
        o_MUL   <= '0;
        o_KSL   <= '0;
        o_AR    <= '0;
        o_DR    <= '0;
        o_SL    <= '0;
        o_RR    <= '0;
    end else begin
        o_CH    <= slot1[4:1];
        o_CAR   <= slot1[0];
        o_FNUM  <= fnum1;
        o_BLOCK <= block1;
        o_KON   <= kon1;
        o_SUSEN <= susen1;
        if (use_cust) begin
            o_TL   <= i_cust.tl;
            o_DC   <= i_cust.dc;
            o_DM   <= i_cust.dm;
            o_FB   <= i_cust.fb;
            o_AM   <= i_cust.am;
            o_PM   <= i_cust.pm;
            o_ETYP <= i_cust.etyp;
            o_KSR  <= i_cust.ksr;
            o_MUL  <= i_cust.mul;
            o_KSL  <= i_cust.ksl;
            o_AR   <= i_cust.ar;
            o_DR   <= i_cust.dr;
            o_SL   <= i_cust.sl;
            o_RR   <= i_cust.rr;
        end else begin
            o_TL   <= i_rom.tl;
            o_DC   <= i_rom.dc;
            o_DM   <= i_rom.dm;
            o_FB   <= i_rom.fb;
            o_AM   <= i_rom.am;
            o_PM   <= i_rom.pm;
            o_ETYP <= i_rom.etyp;
            o_KSR  <= i_rom.ksr;
            o_MUL  <= i_rom.mul;
            o_KSL  <= i_rom.ksl;
            o_AR   <= i_rom.ar;
            o_DR   <= i_rom.dr;
            o_SL   <= i_rom.sl;
            o_RR   <= i_rom.rr;
        end
        if (ph1 == carrier) begin
            o_TL <= {vol1, 2'b00};  // carrier level comes from channel volume
        end
        if (ph1 == modulator && !kon1) begin
            o_AR <= '0;             // hold modulator envelope while key is off
            o_DR <= '0;
            o_RR <= '0;
        end
    end
end

endmodule

`default_nettype wire

//--- hdl/opll_inst_rom.sv
`timescale 1ns/100ps
`default_nettype none

module opll_inst_rom import opll_reg_pkg::*; (
    input  logic            i_EMUCLK,
    input  inst_t           i_inst,
    input  slot_phase_e     i_car,
    opll_patch_if.source    o_patch
);

patch_row_t row_q;
logic       car_q;

// row layout, msb first
// tl(6) dc dm fb(3) am pm etyp ksr (mod,car each) mul ksl ar dr sl rr (mod,car each)
always_ff @(posedge i_EMUCLK) begin
    car_q <= (i_car == carrier);
    case (i_inst)
        4'h0: row_q <= '0;     // user instrument slot
        4'h1: row_q <= 63'b011110_1_0_111_00_11_11_10_00010001_0000_11010111_00001000_00000001_00000111;
        4'h2: row_q <= 63'b011010_0_1_101_00_01_00_10_00110001_0000_11011111_10000111_00100001_00110011;
        4'h3: row_q <= 63'b011001_0_0_000_00_00_00_10_00110001_1000_11111100_00100100_00010010_00010011;
        4'h4: row_q <= 63'b001110_0_0_111_00_01_11_10_00010001_0000_10100110_10000100_01110010_00000111;
        4'h5: row_q <= 63'b011110_0_0_110_00_00_11_10_00100001_0000_11100111_00000110_00000010_00001000;
        4'h6: row_q <= 63'b010110_0_0_101_00_00_11_10_00010010_0000_11100111_00000001_00000001_00001000;
        4'h7: row_q <= 63'b011101_0_0_111_00_01_11_00_00010001_0000_10001000_00100001_00010000_00000111;
        4'h8: row_q <= 63'b101101_1_0_100_00_00_11_00_00110001_0000_10100111_00100010_00000000_00000111;
        4'h9: row_q <= 63'b011011_0_0_110_00_11_11_00_00010001_0000_01100110_01000101_00010001_00000111;
        4'hA: row_q <= 63'b001011_1_1_000_00_11_01_00_00010001_0000_10001111_01010111_01110000_00010111;
        4'hB: row_q <= 63'b000011_1_0_001_00_00_00_10_00110001_1000_11111110_10100100_00010000_00000100;
        4'hC: row_q <= 63'b100100_0_0_111_01_01_00_10_01110001_0000_11111111_10001000_00100001_00100010;
        4'hD: row_q <= 63'b001100_0_0_101_00_11_10_01_00010000_0000_11001111_00100101_00100100_00000010;
        4'hE: row_q <= 63'b010101_0_0_011_00_00_00_00_00010001_0100_11001001_10010101_00000000_00110010;
        4'hF: row_q <= 63'b001001_0_0_011_00_11_10_00_00010001_1000_11111110_00010100_01000001_00000011;
    endcase
end

// shared fields
assign o_patch.tl   = row_q[62:57];
assign o_patch.dc   = row_q[56];
assign o_patch.dm   = row_q[55];
assign o_patch.fb   = row_q[54:52];

// carrier takes the lower half of each pair
assign o_patch.am   = car_q ? row_q[50]    : row_q[51];
assign o_patch.pm   = car_q ? row_q[48]    : row_q[49];
assign o_patch.etyp = car_q ? row_q[46]    : row_q[47];
assign o_patch.ksr  = car_q ? row_q[44]    : row_q[45];
assign o_patch.mul  = car_q ? row_q[39:36] : row_q[43:40];
assign o_patch.ksl  = car_q ? row_q[33:32] : row_q[35:34];
assign o_patch.ar   = car_q ? row_q[27:24] : row_q[31:28];
assign o_patch.dr   = car_q ? row_q[19:16] : row_q[23:20];
assign o_patch.sl   = car_q ? row_q[11:8]  : row_q[15:12];
assign o_patch.rr   = car_q ? row_q[3:0]   : row_q[7:4];

endmodule

`default_nettype wire

//--- hdl/opll_chan_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "opll_reg_config.svh"

module opll_chan_regs import opll_reg_pkg::*; (
    input  logic    i_EMUCLK,
    input  logic    i_RST_n,
    input  logic    i_addr_wr,
    input  logic    i_data_wr,
    input  byte_t   i_wr_data,
    input  ch_t     i_ch,
    output fnum_t   o_fnum,
    output block_t  o_block,
    output logic    o_kon,
    output logic    o_susen,
    output inst_t   o_inst,
    output vol_t    o_vol
);

reg_addr_t  addr_q;
logic       addr_ok;    // last address fell in 0x00..0x3f

fnum_t      fnum_r  [`OPLL_NUM_CH];
block_t     block_r [`OPLL_NUM_CH];
inst_t      inst_r  [`OPLL_NUM_CH];
vol_t       vol_r   [`OPLL_NUM_CH];
logic [`OPLL_NUM_CH-1:0] kon_r, susen_r;

logic [3:0] idx;
reg_addr_t  base;
logic       hit;

assign idx  = addr_q[3:0];
assign base = {addr_q[7:4], 4'h0};
assign hit  = addr_ok && (idx < `OPLL_NUM_CH);  // nibbles 9..f unused

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        addr_q  <= '0;
        addr_ok <= 1'b0;
        kon_r   <= '0;
        susen_r <= '0;
        for (int c = 0; c < `OPLL_NUM_CH; c++) begin
            fnum_r[c]  <= '0;
            block_r[c] <= '0;
            inst_r[c]  <= '0;
            vol_r[c]   <= '0;
        end
    end else begin
        if (i_addr_wr) begin
            addr_ok <= (i_wr_data[7:6] == 2'b00);
            if (i_wr_data[7:6] == 2'b00) begin
                addr_q <= i_wr_data;
            end
        end
        if (i_data_wr && hit) begin
            case (base)
                `OPLL_ADDR_FNUM_LO: fnum_r[idx][7:0] <= i_wr_data;
                `OPLL_ADDR_FNUM_HI: begin
                    fnum_r[idx][8] <= i_wr_data[0];
                    block_r[idx]   <= i_wr_data[3:1];
                    kon_r[idx]     <= i_wr_data[4];
                    susen_r[idx]   <= i_wr_data[5];
                end
                `OPLL_ADDR_INST: {inst_r[idx], vol_r[idx]} <= i_wr_data;
                default: ;      // custom range handled elsewhere
            endcase
        end
    end
end

// read port follows the slot counter
assign o_fnum  = fnum_r[i_ch];
assign o_block = block_r[i_ch];
assign o_kon   = kon_r[i_ch];
assign o_susen = susen_r[i_ch];
assign o_inst  = inst_r[i_ch];
assign o_vol   = vol_r[i_ch];

endmodule

`default_nettype wire

//--- hdl/opll_custom_patch.sv
`timescale 1ns/100ps
`default_nettype none

`include "opll_reg_config.svh"

module opll_custom_patch import opll_reg_pkg::*; (
    input  logic            i_EMUCLK,
    input  logic            i_RST_n,
    input  logic            i_addr_wr,
    input  logic            i_data_wr,
    input  byte_t           i_wr_data,
    input  slot_phase_e     i_car,
    opll_patch_if.source    o_patch
);

reg_addr_t  addr_q;

// per operator fields, index 0 modulator, 1 carrier
logic [1:0] am_r, pm_r, etyp_r, ksr_r;
mul_t       mul_r [2];
ksl_t       ksl_r [2];
rate_t      ar_r  [2];
rate_t      dr_r  [2];
rate_t      sl_r  [2];
rate_t      rr_r  [2];

// shared by both operators
tl_t        tl_r;
logic       dc_r, dm_r;
fb_t        fb_r;

logic       op;

//////////////////////////////////////////////////////////////////////
// register writes 0x00..0x07
//////////////////////////////////////////////////////////////////////

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        addr_q <= '0;
        am_r   <= '0;
        pm_r   <= '0;
        etyp_r <= '0;
        ksr_r  <= '0;
        tl_r   <= '0;
        dc_r   <= 1'b0;
        dm_r   <= 1'b0;
        fb_r   <= '0;
        for (int k = 0; k < 2; k++) begin
            mul_r[k] <= '0;
            ksl_r[k] <= '0;
            ar_r[k]  <= '0;
            dr_r[k]  <= '0;
            sl_r[k]  <= '0;
            rr_r[k]  <= '0;
        end
    end else begin
        if (i_addr_wr) begin
            addr_q <= i_wr_data;    // whole byte, range checked on data write
        end
        if (i_data_wr && addr_q <= `OPLL_CUSTOM_LAST) begin
            case (addr_q[2:0])
                3'd0: {am_r[0], pm_r[0], etyp_r[0], ksr_r[0], mul_r[0]} <= i_wr_data;
                3'd1: {am_r[1], pm_r[1], etyp_r[1], ksr_r[1], mul_r[1]} <= i_wr_data;
                3'd2: {ksl_r[0], tl_r} <= i_wr_data;
                3'd3: {ksl_r[1], dc_r, dm_r, fb_r} <= {i_wr_data[7:6], i_wr_data[4:0]};
                3'd4: {ar_r[0], dr_r[0]} <= i_wr_data;
                3'd5: {ar_r[1], dr_r[1]} <= i_wr_data;
                3'd6: {sl_r[0], rr_r[0]} <= i_wr_data;
                3'd7: {sl_r[1], rr_r[1]} <= i_wr_data;
            endcase
        end
    end
end

//////////////////////////////////////////////////////////////////////
// operator select, one cycle behind the slot
//////////////////////////////////////////////////////////////////////

assign op = (i_car == carrier);

always_ff @(posedge i_EMUCLK) begin
    o_patch.tl   <= tl_r;
    o_patch.dc   <= dc_r;
    o_patch.dm   <= dm_r;
    o_patch.fb   <= fb_r;
    o_patch.am   <= am_r[op];
    o_patch.pm   <= pm_r[op];
    o_patch.etyp <= etyp_r[op];
    o_patch.ksr  <= ksr_r[op];
    o_patch.mul  <= mul_r[op];
    o_patch.ksl  <= ksl_r[op];
    o_patch.ar   <= ar_r[op];
    o_patch.dr   <= dr_r[op];
    o_patch.sl   <= sl_r[op];
    o_patch.rr   <= rr_r[op];
end

endmodule

`default_nettype wire

//--- hdl/opll_bus_sync.sv
`timescale 1ns/100ps
`default_nettype none

`include "opll_reg_config.svh"

module opll_bus_sync import opll_reg_pkg::*; (
    input  logic    i_EMUCLK,
    input  logic    i_RST_n,
    input  logic    i_CS_n,
    input  logic    i_WR_n,
    input  logic    i_A0,
    input  byte_t   i_D,
    output logic    o_addr_wr,
    output logic    o_data_wr,
    output byte_t   o_wr_data
);

localparam int STAGES = `OPLL_SYNC_STAGES;

//////////////////////////////////////////////////////////////////////
// input synchronizers
//////////////////////////////////////////////////////////////////////

logic [STAGES-1:0]  cs_n_sync, wr_n_sync, a0_sync;
byte_t              d_sync [STAGES];
byte_t              wr_data_q;
logic               wr_act;

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        cs_n_sync <= '1;    // bus idle
        wr_n_sync <= '1;
    end else begin
        cs_n_sync <= {cs_n_sync[STAGES-2:0], i_CS_n};
        wr_n_sync <= {wr_n_sync[STAGES-2:0], i_WR_n};
    end
end

always_ff @(posedge i_EMUCLK) begin
    a0_sync   <= {a0_sync[STAGES-2:0], i_A0};
    d_sync[0] <= i_D;
    for (int i = 1; i < STAGES; i++) begin
        d_sync[i] <= d_sync[i-1];
    end
    if (wr_act) begin
        wr_data_q <= d_sync[STAGES-1];  // follows the bus while write is held
    end
end

assign wr_act = !cs_n_sync[STAGES-1] && !wr_n_sync[STAGES-1];

//////////////////////////////////////////////////////////////////////
// request chains, [0] address write, [1] data write
//////////////////////////////////////////////////////////////////////

logic [1:0]         rq, rq_prev;
logic [1:0][2:0]    chain;

assign rq[0] = wr_act && !a0_sync[STAGES-1];
assign rq[1] = wr_act &&  a0_sync[STAGES-1];

always_ff @(posedge i_EMUCLK or negedge i_RST_n) begin
    if (!i_RST_n) begin
        rq_prev <= '0;
        chain   <= '0;
    end else begin
        rq_prev <= rq;
        for (int g = 0; g < 2; g++) begin
            if (chain[g][2]) begin
                chain[g][0] <= 1'b0;        // strobe fired, drop request
            end else if (rq[g] && !rq_prev[g]) begin
                chain[g][0] <= 1'b1;
            end
            chain[g][2:1] <= chain[g][1:0];
        end
    end
end

// rising edge of the chain gives one pulse per access
assign o_addr_wr = chain[0][1] && !chain[0][2];
assign o_data_wr = chain[1][1] && !chain[1][2];
assign o_wr_data = wr_data_q;

endmodule

`default_nettype wire

//--- hdl/opll_patch_if.sv
`timescale 1ns/100ps
`default_nettype none

interface opll_patch_if import opll_reg_pkg::*; ();

    tl_t    tl;
    logic   dc, dm;     // carrier / modulator waveform distortion
    fb_t    fb;
    logic   am, pm, etyp, ksr;
    mul_t   mul;
    ksl_t   ksl;
    rate_t  ar, dr, sl, rr;

    modport source (
        output tl, dc, dm, fb, am, pm, etyp, ksr, mul, ksl, ar, dr, sl, rr
    );

    modport sink (
        input  tl, dc, dm, fb, am, pm, etyp, ksr, mul, ksl, ar, dr, sl, rr
    );

endinterface

`default_nettype wire

//--- hdl/opll_reg_pkg.sv
`default_nettype none

`include "opll_reg_config.svh"

package opll_reg_pkg;

    typedef logic [7:0]                 byte_t;     // cpu bus byte
    typedef logic [7:0]                 reg_addr_t;
    typedef logic [`OPLL_CH_W-1:0]      ch_t;
    typedef logic [`OPLL_SLOT_W-1:0]    slot_t;
    typedef logic [`OPLL_FNUM_W-1:0]    fnum_t;
    typedef logic [2:0]                 block_t;
    typedef logic [3:0]                 inst_t;
    typedef logic [3:0]                 vol_t;
    typedef logic [5:0]                 tl_t;
    typedef logic [3:0]                 rate_t;     // ar, dr, rr and sl
    typedef logic [3:0]                 mul_t;
    typedef logic [1:0]                 ksl_t;
    typedef logic [2:0]                 fb_t;

    // both operators of one built-in patch
    typedef logic [`OPLL_ROW_W-1:0]     patch_row_t;

    // even slot is the modulator, odd slot the carrier
    typedef enum logic {
        modulator = 1'b0,
        carrier   = 1'b1
    } slot_phase_e;

endpackage

`default_nettype wire

//--- hdl/opll_reg_config.svh
`ifndef OPLL_REG_CONFIG_SVH
`define OPLL_REG_CONFIG_SVH

// field widths
`define OPLL_FNUM_W         9
`define OPLL_CH_W           4
`define OPLL_SLOT_W         5
`define OPLL_ROW_W          63

// channel and slot counts
`define OPLL_NUM_CH         9
`define OPLL_NUM_SLOT       18

// register map
`define OPLL_CUSTOM_LAST    8'h07   // last user instrument register
`define OPLL_ADDR_FNUM_LO   8'h10
`define OPLL_ADDR_FNUM_HI   8'h20   // fnum msb, block, key-on, sustain
`define OPLL_ADDR_INST      8'h30   // instrument and volume

`define OPLL_SYNC_STAGES    2       // bus synchronizer depth

`endif
